//--- design/rv_dec_consts.svh
`ifndef RV_DEC_CONSTS_SVH
`define RV_DEC_CONSTS_SVH

// field widths
`define INST_W       32
`define REG_IDX_W    5
`define IMM_W        20
`define QUE_ID_W     2
`define MICRO_OP_W   5
`define OPC_W        7

// dispatch queue ids
`define INTBLOCK_ID      2'd0
`define MEMBLOCK_ID      2'd1
`define UNKNOWNBLOCK_ID  2'd2

// issue queue ids
`define ALUIQ_ID   2'd0
`define MDUIQ_ID   2'd1
`define MISCIQ_ID  2'd2

// free slots in the dispatch queue after reset
`define DEC_CREDITS  4

// major opcodes
`define OPC_OP         7'b0110011
`define OPC_OP_IMM     7'b0010011
`define OPC_OP_32      7'b0111011
`define OPC_OP_IMM_32  7'b0011011
`define OPC_LOAD       7'b0000011
`define OPC_STORE      7'b0100011
`define OPC_BRANCH     7'b1100011
`define OPC_JAL        7'b1101111
`define OPC_JALR       7'b1100111
`define OPC_LUI        7'b0110111
`define OPC_AUIPC      7'b0010111
`define OPC_SYSTEM     7'b1110011

`endif

//--- design/rv_dec_outreg.sv
`timescale 1ns/1ps
`include "rv_dec_consts.svh"

module rv_dec_outreg (
    input  logic                  i_clk,
    input  logic                  i_rst_n,
    input  logic                  i_inst_valid,
    input  logic                  i_credit_return,
    input  rv_dec_pkg::dec_info_t i_dec_info,
    output logic                  o_inst_ready,
    output logic                  o_dec_valid,
    output rv_dec_pkg::dec_info_t o_dec_info
);
    import rv_dec_pkg::*;

    localparam int CNT_W = $clog2(`DEC_CREDITS + 1);

    logic [CNT_W-1:0] credit_cnt;
    logic             accept;
    logic             dec_valid_q;
    dec_info_t        dec_info_q;

    assign o_inst_ready = (credit_cnt != '0);
    assign accept       = i_inst_valid && o_inst_ready;

    // free slots in the dispatch queue
    always_ff @(posedge i_clk) begin
        if (!i_rst_n) begin
            credit_cnt  <= CNT_W'(`DEC_CREDITS);
            dec_valid_q <= 1'b0;
        end else begin
            dec_valid_q <= accept;
            case ({accept, i_credit_return})
                2'b10:   credit_cnt <= credit_cnt - 1'b1;
                2'b01:   credit_cnt <= credit_cnt + 1'b1;
                default: credit_cnt <= credit_cnt;
            endcase
        end
    end

    always_ff @(posedge i_clk) begin
        if (accept) begin
            dec_info_q <= i_dec_info;
        end
    end

    assign o_dec_valid = dec_valid_q;
    assign o_dec_info  = dec_info_q;

endmodule

//--- design/rv_dec_pkg.sv
`include "rv_dec_consts.svh"

package rv_dec_pkg;

    typedef logic [`INST_W-1:0]     inst_t;
    typedef logic [`REG_IDX_W-1:0]  reg_idx_t;
    // u-type values are kept unshifted
    typedef logic [`IMM_W-1:0]      imm20_t;
    typedef logic [`QUE_ID_W-1:0]   que_id_t;
    typedef logic [`MICRO_OP_W-1:0] micro_op_t;

    typedef enum logic [`MICRO_OP_W-1:0] {
        alu_none, alu_lui, alu_add, alu_sub, alu_addw, alu_subw,
        alu_sll, alu_srl, alu_sra, alu_sllw, alu_srlw, alu_sraw,
        alu_xor, alu_or, alu_and, alu_slt, alu_sltu
    } alu_op_e;

    typedef enum logic [`MICRO_OP_W-1:0] {
        mdu_none, mdu_mul, mdu_mulw, mdu_mulh, mdu_mulhu, mdu_mulhsu,
        mdu_div, mdu_divw, mdu_divu, mdu_divuw, mdu_rem, mdu_remw,
        mdu_remu, mdu_remuw
    } mdu_op_e;

    typedef struct packed {
        logic is_int_math;
        logic is_imm_math;
        logic is_cond_branch;
        logic is_jal;
        logic is_jalr;
        logic is_lui;
        logic is_auipc;
        logic is_load;
        logic is_store;
        logic is_mul_div;
        logic is_csr;
        logic is_csr_reg;
        logic is_shift_imm;
        logic is_unknown;
    } inst_class_t;

    typedef struct packed {
        micro_op_t micro_op;
        imm20_t    imm;
        logic      use_imm;
        logic      rd_wen;
        logic      is_mv;
        logic      is_unknown;
        reg_idx_t  rd_idx;
        reg_idx_t  rs1_idx;
        reg_idx_t  rs2_idx;
        que_id_t   disp_que;
        que_id_t   issue_que;
    } dec_info_t;

endpackage

//--- design/rv_decoder.sv
`timescale 1ns/1ps

module rv_decoder (
    input  logic                  i_clk,
    input  logic                  i_rst_n,
    input  logic                  i_inst_valid,
    input  rv_dec_pkg::inst_t     i_inst,
    input  logic                  i_credit_return,
    output logic                  o_inst_ready,
    output logic                  o_dec_valid,
    output rv_dec_pkg::dec_info_t o_dec_info
);
    import rv_dec_pkg::*;

    inst_class_t inst_class;
    micro_op_t   micro_op;
    imm20_t      imm;
    reg_idx_t    rd_idx;
    reg_idx_t    rs1_idx;
    reg_idx_t    rs2_idx;
    logic        rd_wen;
    logic        use_imm;
    logic        is_mv;
    que_id_t     disp_que;
    que_id_t     issue_que;
    dec_info_t   dec_info;

    rv_op_classify rv_op_classify_i (
        .i_inst     (i_inst),
        .o_class    (inst_class),
        .o_micro_op (micro_op)
    );

    rv_imm_gen rv_imm_gen_i (
        .i_inst  (i_inst),
        .i_class (inst_class),
        .o_imm   (imm)
    );

    rv_operand_sel rv_operand_sel_i (
        .i_inst      (i_inst),
        .i_class     (inst_class),
        .i_imm       (imm),
        .o_rd_idx    (rd_idx),
        .o_rs1_idx   (rs1_idx),
        .o_rs2_idx   (rs2_idx),
        .o_rd_wen    (rd_wen),
        .o_use_imm   (use_imm),
        .o_is_mv     (is_mv),
        .o_disp_que  (disp_que),
        .o_issue_que (issue_que)
    );

    always_comb begin
        dec_info.micro_op   = micro_op;
        dec_info.imm        = imm;
        dec_info.use_imm    = use_imm;
        dec_info.rd_wen     = rd_wen;
        dec_info.is_mv      = is_mv;
        dec_info.is_unknown = inst_class.is_unknown;
        dec_info.rd_idx     = rd_idx;
        dec_info.rs1_idx    = rs1_idx;
        dec_info.rs2_idx    = rs2_idx;
        dec_info.disp_que   = disp_que;
        dec_info.issue_que  = issue_que;
    end

    // one cycle from acceptance to o_dec_valid
    rv_dec_outreg rv_dec_outreg_i (
        .i_clk           (i_clk),
        .i_rst_n         (i_rst_n),
        .i_inst_valid    (i_inst_valid),
        .i_credit_return (i_credit_return),
        .i_dec_info      (dec_info),
        .o_inst_ready    (o_inst_ready),
        .o_dec_valid     (o_dec_valid),
        .o_dec_info      (o_dec_info)
    );

endmodule

//--- design/rv_imm_gen.sv
`timescale 1ns/1ps

module rv_imm_gen (
    input  rv_dec_pkg::inst_t       i_inst,
    input  rv_dec_pkg::inst_class_t i_class,
    output rv_dec_pkg::imm20_t      o_imm
);
    import rv_dec_pkg::*;

    imm20_t i_type_imm;
    imm20_t s_type_imm;
    imm20_t u_type_imm;
    imm20_t b_type_imm;
    imm20_t j_type_imm;
    imm20_t csr_imm;
    imm20_t shamt_imm;

    assign i_type_imm = {{8{i_inst[31]}}, i_inst[31:20]};
    assign s_type_imm = {{8{i_inst[31]}}, i_inst[31:25], i_inst[11:7]};
    // shifted left by 12 in the execute stage
    assign u_type_imm = i_inst[31:12];
    assign b_type_imm = {{8{i_inst[31]}}, i_inst[7], i_inst[30:25], i_inst[11:8], 1'b0};
    assign j_type_imm = {i_inst[19:12], i_inst[20], i_inst[30:21], 1'b0};
    // csr address above the rs1/zimm field
    assign csr_imm    = {3'd0, i_inst[31:20], i_inst[19:15]};
    assign shamt_imm  = {14'd0, i_inst[25:20]};

    always_comb begin
        if (i_class.is_lui || i_class.is_auipc) begin
            o_imm = u_type_imm;
        end else if (i_class.is_cond_branch) begin
            o_imm = b_type_imm;
        end else if (i_class.is_store) begin
            o_imm = s_type_imm;
        end else if (i_class.is_load || i_class.is_jalr) begin
            o_imm = i_type_imm;
        end else if (i_class.is_imm_math) begin
            o_imm = i_class.is_shift_imm ? shamt_imm : i_type_imm;
        end else if (i_class.is_jal) begin
            o_imm = j_type_imm;
        end else if (i_class.is_csr) begin
            o_imm = csr_imm;
        end else begin
            o_imm = '0;
        end
    end

endmodule

//--- design/rv_op_classify.sv
`timescale 1ns/1ps
`include "rv_dec_consts.svh"

module rv_op_classify (
    input  rv_dec_pkg::inst_t       i_inst,
    output rv_dec_pkg::inst_class_t o_class,
    output rv_dec_pkg::micro_op_t   o_micro_op
);
    import rv_dec_pkg::*;

    // 64-bit alu ops, shared by OP and OP-IMM
    function automatic alu_op_e base_alu_op(input logic [2:0] f3, input logic alt);
        alu_op_e op;
        case (f3)
            3'b000:  op = alt ? alu_sub : alu_add;
            3'b001:  op = alu_sll;
            3'b010:  op = alu_slt;
            3'b011:  op = alu_sltu;
            3'b100:  op = alu_xor;
            3'b101:  op = alt ? alu_sra : alu_srl;
            3'b110:  op = alu_or;
            default: op = alu_and;
        endcase
        return op;
    endfunction

    function automatic alu_op_e word_alu_op(input logic [2:0] f3, input logic alt);
        alu_op_e op;
        case (f3)
            3'b000:  op = alt ? alu_subw : alu_addw;
            3'b001:  op = alu_sllw;
            3'b101:  op = alt ? alu_sraw : alu_srlw;
            default: op = alu_none;
        endcase
        return op;
    endfunction

    function automatic mdu_op_e mdu_op_sel(input logic [2:0] f3, input logic word);
        mdu_op_e op;
        case (f3)
            3'b000:  op = word ? mdu_mulw : mdu_mul;
            3'b001:  op = word ? mdu_none : mdu_mulh;
            3'b010:  op = word ? mdu_none : mdu_mulhsu;
            3'b011:  op = word ? mdu_none : mdu_mulhu;
            3'b100:  op = word ? mdu_divw : mdu_div;
            3'b101:  op = word ? mdu_divuw : mdu_divu;
            3'b110:  op = word ? mdu_remw : mdu_rem;
            default: op = word ? mdu_remuw : mdu_remu;
        endcase
        return op;
    endfunction

    logic [`OPC_W-1:0] opcode;
    logic [2:0]        funct3;
    logic [6:0]        funct7;
    logic              f7_zero;
    logic              f7_alt;
    logic              f7_mdu;
    logic              alt_f3;
    logic              word_f3;
    logic              shamt_hi_zero;
    inst_class_t       cls;
    alu_op_e           alu_op;
    mdu_op_e           mdu_op;

    assign opcode  = i_inst[6:0];
    assign funct3  = i_inst[14:12];
    assign funct7  = i_inst[31:25];
    assign f7_zero = (funct7 == 7'b0000000);
    assign f7_alt  = (funct7 == 7'b0100000);
    assign f7_mdu  = (funct7 == 7'b0000001);
    // sub/sra style encodings only exist for funct3 000 and 101
    assign alt_f3  = (funct3 == 3'b000) || (funct3 == 3'b101);
    assign word_f3 = alt_f3 || (funct3 == 3'b001);
    // rv64 shifts use a 6-bit shamt, so only inst[31:26] is funct
    assign shamt_hi_zero = (i_inst[31:26] == 6'b000000);

    always_comb begin
        cls    = '0;
        alu_op = alu_none;
        mdu_op = mdu_none;
        case (opcode)
            `OPC_OP: begin
                if (f7_mdu) begin
                    cls.is_mul_div = 1'b1;
                    mdu_op = mdu_op_sel(funct3, 1'b0);
                end else if (f7_zero || (f7_alt && alt_f3)) begin
                    cls.is_int_math = 1'b1;
                    alu_op = base_alu_op(funct3, f7_alt);
                end
            end
            `OPC_OP_32: begin
                if (f7_mdu && (funct3 == 3'b000 || funct3[2])) begin
                    cls.is_mul_div = 1'b1;
                    mdu_op = mdu_op_sel(funct3, 1'b1);
                end else if ((f7_zero && word_f3) || (f7_alt && alt_f3)) begin
                    cls.is_int_math = 1'b1;
                    alu_op = word_alu_op(funct3, f7_alt);
                end
            end
            `OPC_OP_IMM: begin
                if (funct3 == 3'b001 || funct3 == 3'b101) begin
                    cls.is_shift_imm = 1'b1;
                    cls.is_imm_math  = shamt_hi_zero ||
                                       (funct3 == 3'b101 && i_inst[31:26] == 6'b010000);
                end else begin
                    cls.is_imm_math = 1'b1;
                end
                if (cls.is_imm_math) begin
                    alu_op = base_alu_op(funct3, funct3 == 3'b101 && i_inst[30]);
                end
            end
            `OPC_OP_IMM_32: begin
                cls.is_shift_imm = (funct3 != 3'b000);
                cls.is_imm_math  = (funct3 == 3'b000) || (funct3 == 3'b001 && f7_zero) ||
                                   (funct3 == 3'b101 && (f7_zero || f7_alt));
                if (cls.is_imm_math) begin
                    alu_op = word_alu_op(funct3, funct3 == 3'b101 && f7_alt);
                end
            end
            `OPC_LOAD:   cls.is_load = (funct3 != 3'b111);
            `OPC_STORE:  cls.is_store = !funct3[2];
            `OPC_BRANCH: cls.is_cond_branch = (funct3[2:1] != 2'b01);
            `OPC_JAL:    cls.is_jal = 1'b1;
            `OPC_JALR:   cls.is_jalr = (funct3 == 3'b000);
            `OPC_LUI: begin
                cls.is_lui = 1'b1;
                alu_op = alu_lui;
            end
            `OPC_AUIPC:  cls.is_auipc = 1'b1;
            `OPC_SYSTEM: begin
                // funct3 000 and 100 hold ecall/mret/wfi, left unknown
                cls.is_csr     = (funct3[1:0] != 2'b00);
                cls.is_csr_reg = (funct3[1:0] != 2'b00) && !funct3[2];
            end
            default: ;
        endcase
        cls.is_unknown = !(cls.is_int_math | cls.is_imm_math | cls.is_cond_branch |
                           cls.is_jal | cls.is_jalr | cls.is_lui | cls.is_auipc |
                           cls.is_load | cls.is_store | cls.is_mul_div | cls.is_csr);
    end

    assign o_class    = cls;
    assign o_micro_op = (alu_op != alu_none) ? micro_op_t'(alu_op) : micro_op_t'(mdu_op);

endmodule

//--- design/rv_operand_sel.sv
`timescale 1ns/1ps
`include "rv_dec_consts.svh"

module rv_operand_sel (
    input  rv_dec_pkg::inst_t       i_inst,
    input  rv_dec_pkg::inst_class_t i_class,
    input  rv_dec_pkg::imm20_t      i_imm,
    output rv_dec_pkg::reg_idx_t    o_rd_idx,
    output rv_dec_pkg::reg_idx_t    o_rs1_idx,
    output rv_dec_pkg::reg_idx_t    o_rs2_idx,
    output logic                    o_rd_wen,
    output logic                    o_use_imm,
    output logic                    o_is_mv,
    output rv_dec_pkg::que_id_t     o_disp_que,
    output rv_dec_pkg::que_id_t     o_issue_que
);
    import rv_dec_pkg::*;

    reg_idx_t rd;
    reg_idx_t rs1;
    reg_idx_t rs2;
    logic     writes_rd;
    logic     reads_rs1;
    logic     reads_rs2;
    logic     base_add;

    assign rd  = i_inst[11:7];
    assign rs1 = i_inst[19:15];
    assign rs2 = i_inst[24:20];

    assign writes_rd = i_class.is_int_math | i_class.is_imm_math | i_class.is_mul_div |
                       i_class.is_lui | i_class.is_auipc | i_class.is_jal |
                       i_class.is_jalr | i_class.is_load | i_class.is_csr;
    // csr immediate forms carry zimm in the rs1 field
    assign reads_rs1 = !i_class.is_unknown && !(i_class.is_lui || i_class.is_auipc ||
                       i_class.is_jal || (i_class.is_csr && !i_class.is_csr_reg));
    assign reads_rs2 = i_class.is_int_math | i_class.is_mul_div |
                       i_class.is_store | i_class.is_cond_branch;

    assign o_rd_idx  = rd;
    assign o_rs1_idx = reads_rs1 ? rs1 : '0;
    assign o_rs2_idx = reads_rs2 ? rs2 : '0;
    assign o_rd_wen  = writes_rd && (rd != '0);
    assign o_use_imm = i_class.is_imm_math;

    // addi/add with funct3 000 and rd == rs1
    assign base_add = (i_inst[14:12] == 3'b000) && (rd == rs1);
    assign o_is_mv  = base_add && ((i_class.is_imm_math && i_inst[6:0] == `OPC_OP_IMM &&
                      i_imm == '0) || (i_class.is_int_math && i_inst[6:0] == `OPC_OP &&
                      i_inst[31:25] == 7'b0000000 && rs2 == '0));

    assign o_disp_que = i_class.is_unknown ? `UNKNOWNBLOCK_ID :
                        (i_class.is_load || i_class.is_store) ? `MEMBLOCK_ID :
                        `INTBLOCK_ID;

    // lui runs on the alu as rd = x0 + imm
    assign o_issue_que = (i_class.is_int_math || i_class.is_imm_math || i_class.is_lui) ?
                         `ALUIQ_ID : i_class.is_mul_div ? `MDUIQ_ID : `MISCIQ_ID;

endmodule

//--- project.f
+incdir+design
design/rv_dec_pkg.sv
design/rv_op_classify.sv
design/rv_imm_gen.sv
design/rv_operand_sel.sv
design/rv_dec_outreg.sv
design/rv_decoder.sv
sim/tb_rv_decoder.sv

//--- run_sim.sh
#!/bin/sh
# build and run the decoder testbench with Verilator
set -e

cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing -Wno-fatal -f project.f \
    --top-module tb_rv_decoder -o sim_rv_decoder

./obj_dir/sim_rv_decoder | tee sim.log

if grep -q "Simulation failed" sim.log; then
    exit 1
fi

//--- sim/rv_decoder_tests.txt
# inst     op imm   rd rs1 rs2 wen use_imm mv unk disp issue
# all columns hex, op is the alu or mdu micro-op code, disp/issue are queue ids
002081b3 02 00000 03 01 02 1 0 0 0 0 0
40c58533 03 00000 0a 0b 0c 1 0 0 0 0 0
007312bb 09 00000 05 06 07 1 0 0 0 0 0
fff4c413 0c fffff 08 09 00 1 1 0 0 0 0
00513093 10 00005 01 02 00 1 1 0 0 0 0
4032521b 0b 00003 04 04 00 1 1 0 0 0 0
123454b7 01 12345 09 00 00 1 0 0 0 0 0
00813283 00 00008 05 02 00 1 0 0 0 1 2
fe63ae23 00 ffffc 1c 07 06 0 0 0 0 1 2
00208863 00 00010 10 01 02 0 0 0 0 0 2
fe419ce3 00 ffff8 19 03 04 0 0 0 0 0 2
001000ef 00 00800 01 00 00 1 0 0 0 0 2
00008067 00 00000 00 01 00 0 0 0 0 0 2
fffff117 00 fffff 02 00 00 1 0 0 0 0 2
300312f3 00 06006 05 06 00 1 0 0 0 0 2
3414d3f3 00 06829 07 00 00 1 0 0 0 0 2
023100b3 01 00000 01 02 03 1 0 0 0 0 1
0262a233 05 00000 04 05 06 1 0 0 0 0 1
029453bb 09 00000 07 08 09 1 0 0 0 0 1
02c5e53b 0b 00000 0a 0b 0c 1 0 0 0 0 1
00000073 00 00000 00 00 00 0 0 0 1 2 2
003100d3 00 00000 01 00 00 0 0 0 1 2 2
202081b3 00 00000 03 00 00 0 0 0 1 2 2
00028293 02 00000 05 05 00 1 1 1 0 0 0
000383b3 02 00000 07 07 00 1 0 1 0 0 0
00208033 02 00000 00 01 02 0 0 0 0 0 0

//--- sim/tb_rv_decoder.sv
`timescale 1ns/1ps
`include "rv_dec_consts.svh"

module tb_rv_decoder;
    import rv_dec_pkg::*;

    localparam int WAIT_LIMIT = 20;

    logic      clk;
    logic      rst_n;
    logic      inst_valid;
    inst_t     inst;
    logic      auto_ret;
    logic      manual_ret;
    logic      credit_return;
    logic      inst_ready;
    logic      dec_valid;
    dec_info_t dec_info;

    // expected results in acceptance order
    dec_info_t exp_q[$];
    inst_t     exp_inst_q[$];
    int        exp_cyc_q[$];

    int cyc;
    int out_count;
    int acc_count;
    int dec_errors;
    int ready_errors;
    int count_errors;
    int wait_errors;
    int file_errors;
    bit return_credits;

    assign credit_return = auto_ret || manual_ret;

    rv_decoder rv_decoder_i (
        .i_clk           (clk),
        .i_rst_n         (rst_n),
        .i_inst_valid    (inst_valid),
        .i_inst          (inst),
        .i_credit_return (credit_return),
        .o_inst_ready    (inst_ready),
        .o_dec_valid     (dec_valid),
        .o_dec_info      (dec_info)
    );

    always #5 clk = ~clk;

    always @(posedge clk) begin
        cyc <= cyc + 1;
    end

    function automatic string info_text(input dec_info_t d);
        return $sformatf(
            "op %h imm %h rd %0d rs1 %0d rs2 %0d wen %b use_imm %b mv %b unk %b que %0d/%0d",
            d.micro_op, d.imm, d.rd_idx, d.rs1_idx, d.rs2_idx, d.rd_wen,
            d.use_imm, d.is_mv, d.is_unknown, d.disp_que, d.issue_que);
    endfunction

    task automatic check_dec_info(input dec_info_t act, input dec_info_t want, input inst_t word);
        if (act !== want) begin
            $display("Error at %0t: decode of %h mismatch", $time, word);
            $display("  got      %s", info_text(act));
            $display("  expected %s", info_text(want));
            dec_errors++;
        end
    endtask

    task automatic check_ready(input logic act, input logic want);
        if (act !== want) begin
            $display("Error at %0t: o_inst_ready is %b, expected %b", $time, act, want);
            ready_errors++;
        end
    endtask

    task automatic check_count(input int act, input int want, input string what);
        if (act != want) begin
            $display("Error at %0t: %s is %0d, expected %0d", $time, what, act, want);
            count_errors++;
        end
    endtask

    // acceptance happens on the coming rising edge
    task automatic expect_output(input inst_t word, input dec_info_t want);
        exp_q.push_back(want);
        exp_inst_q.push_back(word);
        exp_cyc_q.push_back(cyc + 1);
        acc_count++;
    endtask

    // runs from a falling edge to the falling edge after acceptance
    task automatic send_inst(input inst_t word, input dec_info_t want);
        int n;
        n = 0;
        inst_valid = 1'b1;
        inst = word;
        while (!inst_ready && n < WAIT_LIMIT) begin
            @(negedge clk);
            n++;
        end
        if (inst_ready) begin
            expect_output(word, want);
        end else begin
            $display("Timeout at %0t: o_inst_ready stayed low, %h was not sent", $time, word);
            wait_errors++;
        end
        @(negedge clk);
    endtask

    task automatic wait_drain();
        int n;
        n = 0;
        while (exp_q.size() != 0 && n < WAIT_LIMIT) begin
            @(posedge clk);
            n++;
        end
        if (exp_q.size() != 0) begin
            $display("Timeout at %0t: %0d decode results never came out", $time, exp_q.size());
            wait_errors++;
            exp_q.delete();
            exp_inst_q.delete();
            exp_cyc_q.delete();
        end
        @(negedge clk);
    endtask

    // consumer hands a slot back after each result
    always @(negedge clk) begin
        auto_ret = 1'b0;
        if (rst_n && dec_valid) begin
            out_count++;
            if (exp_q.size() == 0) begin
                $display("Output at %0t with no accepted instruction left for it", $time);
                count_errors++;
            end else begin
                check_dec_info(dec_info, exp_q.pop_front(), exp_inst_q.pop_front());
                check_count(cyc, exp_cyc_q.pop_front(), "output cycle");
            end
            if (return_credits) begin
                auto_ret = 1'b1;
            end
        end
    end

    initial begin
        int        fd;
        int        n;
        int        k;
        int        n_vectors;
        int        acc_before;
        int        out_before;
        int        total;
        string     line;
        logic [31:0] f_inst;
        logic [4:0]  f_op;
        logic [19:0] f_imm;
        logic [4:0]  f_rd;
        logic [4:0]  f_rs1;
        logic [4:0]  f_rs2;
        logic        f_wen;
        logic        f_use;
        logic        f_mv;
        logic        f_unk;
        logic [1:0]  f_dq;
        logic [1:0]  f_iq;
        dec_info_t   want;
        dec_info_t   first_want;
        inst_t       first_inst;

        clk = 1'b0;
        rst_n = 1'b0;
        inst_valid = 1'b0;
        inst = '0;
        auto_ret = 1'b0;
        manual_ret = 1'b0;
        return_credits = 1'b1;
        out_count = 0;
        acc_count = 0;
        dec_errors = 0;
        ready_errors = 0;
        count_errors = 0;
        wait_errors = 0;
        file_errors = 0;
        n_vectors = 0;
        first_want = '0;
        first_inst = '0;

        repeat (3) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;
        check_ready(inst_ready, 1'b1);
        repeat (2) @(negedge clk);
        check_count(out_count, 0, "outputs while idle");

        fd = $fopen("sim/rv_decoder_tests.txt", "r");
        if (fd == 0) begin
            $display("Could not open the test vector file sim/rv_decoder_tests.txt");
            file_errors++;
        end else begin
            while ($fgets(line, fd) != 0) begin
                n = $sscanf(line, "%h %h %h %h %h %h %h %h %h %h %h %h", f_inst, f_op, f_imm,
                            f_rd, f_rs1, f_rs2, f_wen, f_use, f_mv, f_unk, f_dq, f_iq);
                if (n == 12) begin
                    want.micro_op   = f_op;
                    want.imm        = f_imm;
                    want.use_imm    = f_use;
                    want.rd_wen     = f_wen;
                    want.is_mv      = f_mv;
                    want.is_unknown = f_unk;
                    want.rd_idx     = f_rd;
                    want.rs1_idx    = f_rs1;
                    want.rs2_idx    = f_rs2;
                    want.disp_que   = f_dq;
                    want.issue_que  = f_iq;
                    if (n_vectors == 0) begin
                        first_want = want;
                        first_inst = f_inst;
                    end
                    send_inst(f_inst, want);
                    n_vectors++;
                end else if (n > 0) begin
                    $display("Malformed line in the test vector file: %s", line);
                    file_errors++;
                end
            end
            $fclose(fd);
        end
        inst_valid = 1'b0;
        if (n_vectors == 0) begin
            $display("No test vectors were read from the test vector file");
            file_errors++;
        end
        wait_drain();

        // credit test with the consumer keeping every slot
        @(negedge clk);
        return_credits = 1'b0;
        check_ready(inst_ready, 1'b1);
        acc_before = acc_count;
        out_before = out_count;
        inst_valid = 1'b1;
        inst = first_inst;
        for (k = 0; k < `DEC_CREDITS + 3; k++) begin
            check_ready(inst_ready, (acc_count - acc_before) < `DEC_CREDITS);
            if (inst_ready) begin
                expect_output(first_inst, first_want);
            end
            @(negedge clk);
        end
        manual_ret = 1'b1;
        @(negedge clk);
        manual_ret = 1'b0;
        check_ready(inst_ready, 1'b1);
        if (inst_ready) begin
            expect_output(first_inst, first_want);
        end
        @(negedge clk);
        check_ready(inst_ready, 1'b0);
        inst_valid = 1'b0;
        wait_drain();
        check_count(acc_count - acc_before, `DEC_CREDITS + 1, "acceptances in credit test");
        check_count(out_count - out_before, acc_count - acc_before, "outputs in credit test");
        check_count(out_count, acc_count, "total outputs");

        total = dec_errors + ready_errors + count_errors + wait_errors + file_errors;
        $display("Errors: decode %0d, ready %0d, count %0d, timeout %0d, file %0d",
                 dec_errors, ready_errors, count_errors, wait_errors, file_errors);
        if (total == 0) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule
